// ==== lane_pkg.sv ====
package lane_pkg;

  typedef logic [31:0] lane_data_t;  // one lane word, byte 0 sent first
  typedef logic [3:0]  lane_k_t;     // k flag per byte
  typedef logic [1:0]  byte_rot_t;   // receive byte rotation 0..3
  typedef logic [15:0] cnt_t;        // statistic counter

  // word on the lane, data plus its k flags
  typedef struct packed {
    lane_data_t data;
    lane_k_t    k;
  } lane_word_t;

  // realigned receive word
  typedef struct packed {
    logic       valid;  // seed or payload word
    logic       first;  // seed word of a frame
    lane_data_t data;
  } aligned_t;

  // statistics snapshot returned on the readout port
  typedef struct packed {
    logic locked;  // one clean frame seen
    cnt_t frames;
    cnt_t errors;
  } lane_stat_t;

  localparam lane_data_t COMMA_WORD = 32'hBCBC_BCBC;  // k28.5 in every byte
  localparam lane_k_t    COMMA_K    = 4'b1111;
  localparam int COMMA_LEN   = 8;   // comma words per frame
  localparam int PAYLOAD_LEN = 55;  // counting words after the seed
  localparam int FRAME_LEN   = COMMA_LEN + 1 + PAYLOAD_LEN;

  typedef enum logic [1:0] {
    GEN_COMMA,
    GEN_SEED,
    GEN_PAYLOAD
  } gen_state_e;

  typedef enum logic {
    HS_IDLE,
    HS_ACK
  } hs_state_e;

endpackage

// ==== frame_gen.sv ====
`timescale 1ns/10ps

module frame_gen (
  input  logic                 txclk,
  input  logic                 tx_rstn,
  output lane_pkg::lane_word_t o_tx
);

  lane_pkg::gen_state_e                   state;     // section now on o_tx
  logic [$clog2(lane_pkg::FRAME_LEN)-1:0] word_cnt;  // words sent in this section

  // o_tx always holds the word of the current state, the next word is
  // chosen from the state and the count
  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      state     <= lane_pkg::GEN_COMMA;
      word_cnt  <= '0;
      o_tx.data <= lane_pkg::COMMA_WORD;  // first comma right out of reset
      o_tx.k    <= lane_pkg::COMMA_K;
    end else begin
      case (state)
        lane_pkg::GEN_COMMA: begin
          if (word_cnt == lane_pkg::COMMA_LEN - 1) begin
            state     <= lane_pkg::GEN_SEED;
            word_cnt  <= '0;
            o_tx.data <= '0;  // zero seed
            o_tx.k    <= '0;
          end else begin
            word_cnt  <= word_cnt + 1'b1;
            o_tx.data <= lane_pkg::COMMA_WORD;
            o_tx.k    <= lane_pkg::COMMA_K;
          end
        end
        lane_pkg::GEN_SEED: begin
          state     <= lane_pkg::GEN_PAYLOAD;
          word_cnt  <= '0;
          o_tx.data <= o_tx.data + 1'b1;  // payload starts at 1
          o_tx.k    <= '0;
        end
        lane_pkg::GEN_PAYLOAD: begin
          if (word_cnt == lane_pkg::PAYLOAD_LEN - 1) begin
            state     <= lane_pkg::GEN_COMMA;  // wrap to the preamble
            word_cnt  <= '0;
            o_tx.data <= lane_pkg::COMMA_WORD;
            o_tx.k    <= lane_pkg::COMMA_K;
          end else begin
            word_cnt  <= word_cnt + 1'b1;
            o_tx.data <= o_tx.data + 1'b1;
            o_tx.k    <= '0;
          end
        end
        default: begin
          state     <= lane_pkg::GEN_COMMA;
          word_cnt  <= '0;
          o_tx.data <= lane_pkg::COMMA_WORD;
          o_tx.k    <= lane_pkg::COMMA_K;
        end
      endcase
    end
  end

endmodule

// ==== comma_decode.sv ====
`timescale 1ns/10ps

module comma_decode (
  input  logic                 txclk,
  input  logic                 tx_rstn,
  input  lane_pkg::lane_word_t i_rx,
  output lane_pkg::byte_rot_t  o_rot,
  output logic                 o_start
);

  logic                prev_allk;  // last word was all k
  logic                edge_hit;   // comma to data boundary in this word
  lane_pkg::byte_rot_t rot_next;

  // after an all-k word, the k flags left in the low bytes are the tail
  // of the preamble, so their count is the rotation
  always_comb begin
    edge_hit = prev_allk;
    rot_next = 2'd0;
    case (i_rx.k)
      4'b0000: rot_next = 2'd0;
      4'b0001: rot_next = 2'd1;
      4'b0011: rot_next = 2'd2;
      4'b0111: rot_next = 2'd3;
      default: edge_hit = 1'b0;  // not a clean boundary
    endcase
  end

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      prev_allk <= 1'b0;
      o_rot     <= '0;
      o_start   <= 1'b0;
    end else begin
      prev_allk <= (i_rx.k == lane_pkg::COMMA_K);
      o_start   <= edge_hit;  // one pulse per boundary
      if (edge_hit) begin
        o_rot <= rot_next;  // held until the next boundary
      end
    end
  end

endmodule

// ==== word_align.sv ====
`timescale 1ns/10ps

module word_align (
  input  logic                 txclk,
  input  logic                 tx_rstn,
  input  lane_pkg::lane_word_t i_rx,
  input  lane_pkg::byte_rot_t  i_rot,
  input  logic                 i_start,
  output lane_pkg::aligned_t   o_aligned
);

  lane_pkg::lane_data_t                   rx_d1;     // rx delayed one word
  lane_pkg::lane_data_t                   rx_d2;     // rx delayed two words
  lane_pkg::lane_data_t                   shuffled;  // word completed by rx_d1
  lane_pkg::lane_data_t                   data_q;
  logic                                   valid_q;
  logic                                   first_q;
  logic                                   pend;      // seed completes one word late
  logic                                   take_seed;
  logic [$clog2(lane_pkg::FRAME_LEN)-1:0] pay_cnt;   // words out since the seed

  // with rotation s the low s bytes of a word belong to the previous word
  always_comb begin
    case (i_rot)
      2'd0:    shuffled = rx_d1;
      2'd1:    shuffled = {rx_d1[7:0], rx_d2[31:8]};
      2'd2:    shuffled = {rx_d1[15:0], rx_d2[31:16]};
      default: shuffled = {rx_d1[23:0], rx_d2[31:24]};
    endcase
  end

  always_ff @(posedge txclk) begin
    rx_d1  <= i_rx.data;
    rx_d2  <= rx_d1;
    data_q <= shuffled;
  end

  // unrotated seed is already in rx_d1 at the strobe, otherwise wait a word
  assign take_seed = (i_start && (i_rot == 2'd0)) || pend;

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      pend    <= 1'b0;
      valid_q <= 1'b0;
      first_q <= 1'b0;
      pay_cnt <= '0;
    end else begin
      pend <= i_start && (i_rot != 2'd0);
      if (take_seed) begin
        valid_q <= 1'b1;
        first_q <= 1'b1;
        pay_cnt <= '0;
      end else if (valid_q && (pay_cnt != lane_pkg::PAYLOAD_LEN)) begin
        valid_q <= 1'b1;
        first_q <= 1'b0;
        pay_cnt <= pay_cnt + 1'b1;
      end else begin
        valid_q <= 1'b0;  // end of payload
        first_q <= 1'b0;
      end
    end
  end

  always_comb begin
    o_aligned.valid = valid_q;
    o_aligned.first = first_q;
    o_aligned.data  = data_q;
  end

endmodule

// ==== seq_check.sv ====
`timescale 1ns/10ps

module seq_check (
  input  logic                 txclk,
  input  logic                 tx_rstn,
  input  lane_pkg::aligned_t   i_aligned,
  input  logic                 i_stat_req,
  output logic                 o_stat_ack,
  output lane_pkg::lane_stat_t o_stat
);

  logic                                   locked;
  lane_pkg::cnt_t                         frames;
  lane_pkg::cnt_t                         errors;
  logic                                   frame_bad;  // error earlier in this frame
  logic [$clog2(lane_pkg::FRAME_LEN)-1:0] word_idx;   // index of the next word
  lane_pkg::lane_data_t                   prev_data;
  lane_pkg::hs_state_e                    hs_state;
  lane_pkg::lane_stat_t                   stat_q;

  logic [$clog2(lane_pkg::FRAME_LEN)-1:0] cur_idx;
  lane_pkg::lane_data_t                   expect_data;
  logic                                   mism;
  logic                                   last_word;
  logic                                   bad_now;

  // seed must be zero, every later word one above the word before it
  always_comb begin
    cur_idx     = i_aligned.first ? '0 : word_idx;
    expect_data = i_aligned.first ? '0 : prev_data + 1'b1;
    mism        = i_aligned.valid && (i_aligned.data != expect_data);
    last_word   = i_aligned.valid && (cur_idx == lane_pkg::PAYLOAD_LEN);
    bad_now     = mism || (frame_bad && !i_aligned.first);
  end

  always_ff @(posedge txclk) begin
    if (i_aligned.valid) begin
      prev_data <= i_aligned.data;
    end
  end

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      locked    <= 1'b0;
      frames    <= '0;
      errors    <= '0;
      frame_bad <= 1'b0;
      word_idx  <= '0;
    end else if (i_aligned.valid) begin
      word_idx <= cur_idx + 1'b1;
      if (mism) begin
        errors <= errors + 1'b1;
      end
      if (last_word) begin
        frames    <= frames + 1'b1;  // clean or not, the frame is done
        frame_bad <= 1'b0;
        if (!bad_now) begin
          locked <= 1'b1;
        end
      end else begin
        frame_bad <= bad_now;
      end
    end
  end

  // four-phase readout, snapshot taken when the request is seen
  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      hs_state <= lane_pkg::HS_IDLE;
    end else begin
      case (hs_state)
        lane_pkg::HS_IDLE: if (i_stat_req) hs_state <= lane_pkg::HS_ACK;
        lane_pkg::HS_ACK:  if (!i_stat_req) hs_state <= lane_pkg::HS_IDLE;
        default:           hs_state <= lane_pkg::HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge txclk) begin
    if ((hs_state == lane_pkg::HS_IDLE) && i_stat_req) begin
      stat_q <= '{locked: locked, frames: frames, errors: errors};
    end
  end

  assign o_stat_ack = (hs_state == lane_pkg::HS_ACK);
  assign o_stat     = stat_q;  // frozen while ack is high

endmodule

// ==== lane_top.sv ====
`timescale 1ns/10ps

module lane_top (
  input  logic                 txclk,
  input  logic                 tx_rstn,
  input  lane_pkg::lane_word_t i_rx,
  output lane_pkg::lane_word_t o_tx,
  output lane_pkg::aligned_t   o_aligned,
  input  logic                 i_stat_req,
  output logic                 o_stat_ack,
  output lane_pkg::lane_stat_t o_stat
);

  lane_pkg::byte_rot_t rx_rot;    // decoded rotation
  logic                rx_start;  // data start strobe

  frame_gen frame_gen_i (
    .txclk   (txclk),
    .tx_rstn (tx_rstn),
    .o_tx    (o_tx)
  );

  // receive path, fed from the loopback outside the top level
  comma_decode comma_decode_i (
    .txclk   (txclk),
    .tx_rstn (tx_rstn),
    .i_rx    (i_rx),
    .o_rot   (rx_rot),
    .o_start (rx_start)
  );

  word_align word_align_i (
    .txclk     (txclk),
    .tx_rstn   (tx_rstn),
    .i_rx      (i_rx),
    .i_rot     (rx_rot),
    .i_start   (rx_start),
    .o_aligned (o_aligned)
  );

  seq_check seq_check_i (
    .txclk      (txclk),
    .tx_rstn    (tx_rstn),
    .i_aligned  (o_aligned),
    .i_stat_req (i_stat_req),
    .o_stat_ack (o_stat_ack),
    .o_stat     (o_stat)
  );

endmodule

// ==== lane_chk.sv ====
`timescale 1ns/10ps

module lane_chk (
  input logic                 txclk,
  input logic                 tx_rstn,
  input logic                 i_req,
  input logic                 i_ack,
  input lane_pkg::lane_stat_t i_stat,
  input logic                 i_valid
);

  int run_len;       // consecutive valid words seen so far
  int fail_cnt = 0;  // failed assertions

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      run_len <= 0;
    end else begin
      run_len <= i_valid ? run_len + 1 : 0;
    end
  end

  ack_after_req: assert property (@(posedge txclk) disable iff (!tx_rstn)
    $rose(i_ack) |-> $past(i_req))
    else begin
      fail_cnt++;
      $error("ack rose without a request");
    end

  stat_held: assert property (@(posedge txclk) disable iff (!tx_rstn)
    (i_ack && $past(i_ack)) |-> $stable(i_stat))
    else begin
      fail_cnt++;
      $error("stat moved during ack");
    end

  valid_len: assert property (@(posedge txclk) disable iff (!tx_rstn)
    i_valid |-> (run_len < lane_pkg::PAYLOAD_LEN + 1))
    else begin
      fail_cnt++;
      $error("valid run too long");
    end

endmodule

bind seq_check lane_chk lane_chk_i (
  .txclk   (txclk),
  .tx_rstn (tx_rstn),
  .i_req   (i_stat_req),
  .i_ack   (o_stat_ack),
  .i_stat  (o_stat),
  .i_valid (i_aligned.valid)
);

// ==== tb_lane.sv ====
`timescale 1ns/10ps

module tb_lane;

  // frames per test: pattern 2, rotations 4 x 3, clean 7, corrupt 7, handshake 3, no comma 2
  localparam int TEST_FRAMES = 2 + 4 * 3 + 7 + 7 + 3 + 2;
  localparam int RESETS = 9;
  localparam int LIMIT = TEST_FRAMES * lane_pkg::FRAME_LEN + RESETS * 16 + 64;

  logic txclk = 1'b0;
  logic tx_rstn;
  lane_pkg::lane_word_t i_rx, o_tx, tx_prev, cur_word;
  lane_pkg::aligned_t   o_aligned;
  logic                 i_stat_req, o_stat_ack;
  lane_pkg::lane_stat_t o_stat, st, st2;
  lane_pkg::byte_rot_t  rot;
  logic hold_comma, corrupt_on;
  lane_pkg::lane_data_t corrupt_idx, corrupt_mask;
  int tx_seeds, corrupt_frame, cycles, mism, fails, tests, nfr, base, r0;
  int asrt_fails;

  lane_top lane_top_i (
    .txclk      (txclk),
    .tx_rstn    (tx_rstn),
    .i_rx       (i_rx),
    .o_tx       (o_tx),
    .o_aligned  (o_aligned),
    .i_stat_req (i_stat_req),
    .o_stat_ack (o_stat_ack),
    .o_stat     (o_stat)
  );

  always #50 txclk = ~txclk;

  // byte j of the rx word is stream byte 4n+j-s
  function automatic lane_pkg::lane_word_t rotate(lane_pkg::lane_word_t cur,
      lane_pkg::lane_word_t prev, lane_pkg::byte_rot_t s);
    lane_pkg::lane_word_t w;
    if (s == 0) return cur;
    w.data = (cur.data << (8 * s)) | (prev.data >> (32 - 8 * s));
    w.k    = (cur.k << s) | (prev.k >> (4 - s));
    return w;
  endfunction

  // loopback model with optional corruption of one payload word
  always @(posedge txclk) begin
    cur_word = o_tx;
    if (corrupt_on && tx_seeds == corrupt_frame && cur_word.k == 0 &&
        cur_word.data == corrupt_idx)
      cur_word.data = cur_word.data ^ corrupt_mask;
    i_rx <= hold_comma ? {lane_pkg::COMMA_WORD, lane_pkg::COMMA_K}
                       : rotate(cur_word, tx_prev, rot);
    if (!tx_rstn) begin
      tx_prev  <= '{data: lane_pkg::COMMA_WORD, k: lane_pkg::COMMA_K};
      tx_seeds <= 0;
    end else begin
      tx_prev <= cur_word;
      if (o_tx.k == 0 && o_tx.data == 0) tx_seeds <= tx_seeds + 1;  // seeds sent
    end
  end

  always @(posedge txclk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run exceeded %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("error %s: expected %0h actual %0h", name, exp, act);
      mism++;
    end
  endtask

  task automatic apply_reset();
    tx_rstn <= 1'b0;
    repeat (16) @(posedge txclk);
    tx_rstn <= 1'b1;
  endtask

  task automatic wait_seeds(input int n);
    while (tx_seeds < n) @(posedge txclk);
  endtask

  task automatic read_stat(input string name, output lane_pkg::lane_stat_t s);
    int g;
    g = 0;
    i_stat_req <= 1'b1;
    do begin
      @(posedge txclk);
      g++;
    end while (!o_stat_ack && g < 8);
    if (!o_stat_ack) begin
      $display("%s: ack never came", name);
      mism++;
    end
    s = o_stat;
    i_stat_req <= 1'b0;
    g = 0;
    do begin
      @(posedge txclk);
      g++;
    end while (o_stat_ack && g < 8);
    if (o_stat_ack) begin
      $display("%s: ack stuck high", name);
      mism++;
    end
  endtask

  task automatic check_aligned(input string name, input int nframes);
    int idx, done, guard;
    idx = 0;
    done = 0;
    guard = 0;
    while (done < nframes && guard < (nframes + 1) * lane_pkg::FRAME_LEN) begin
      @(posedge txclk);
      guard++;
      if (o_aligned.valid) begin
        compare_val(name, idx == 0, o_aligned.first);
        compare_val(name, idx, o_aligned.data);
        idx++;
        if (idx == lane_pkg::PAYLOAD_LEN + 1) begin
          idx = 0;
          done++;
        end
      end
    end
    if (done < nframes) begin
      $display("%s: aligned frames missing", name);
      mism++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (mism != base) fails++;
    $display("test %s %s", name, (mism != base) ? "FAILED" : "ok");
    base = mism;
  endtask

  initial begin
    void'($urandom(32'h3ce0));
    {tx_rstn, i_stat_req, hold_comma, corrupt_on, rot} = '0;
    {corrupt_idx, corrupt_mask, corrupt_frame, cycles, mism, fails, tests, base} = '0;
    i_rx = '{data: lane_pkg::COMMA_WORD, k: lane_pkg::COMMA_K};

    apply_reset();  // first edge samples tx position 0
    for (int c = 0; c < 2 * lane_pkg::FRAME_LEN; c++) begin
      @(posedge txclk);
      if (c % 64 < lane_pkg::COMMA_LEN)
        compare_val("tx_pattern", {lane_pkg::COMMA_WORD, lane_pkg::COMMA_K}, o_tx);
      else
        compare_val("tx_pattern", {32'(c % 64 - lane_pkg::COMMA_LEN), 4'h0}, o_tx);
    end
    end_test("tx_pattern");

    r0 = $urandom % 4;
    for (int i = 0; i < 4; i++) begin
      rot = lane_pkg::byte_rot_t'(r0 + i);
      apply_reset();
      check_aligned("align_rot", 2);
    end
    end_test("align_rot");

    nfr = 3 + $urandom % 4;
    rot = $urandom % 4;
    apply_reset();
    wait_seeds(nfr + 1);
    read_stat("clean_count", st);
    compare_val("clean_count", {1'b1, 16'(nfr), 16'h0}, st);
    end_test("clean_count");

    nfr = 3 + $urandom % 4;
    corrupt_frame = 2 + $urandom % (nfr - 1);
    corrupt_idx = 1 + $urandom % (lane_pkg::PAYLOAD_LEN - 1);
    corrupt_mask = 32'hFF << (8 * ($urandom % 4));
    corrupt_on = 1'b1;
    apply_reset();
    wait_seeds(nfr + 1);
    read_stat("corrupt_count", st);
    compare_val("corrupt_count", {1'b1, 16'(nfr), 16'h2}, st);
    corrupt_on = 1'b0;
    end_test("corrupt_count");

    apply_reset();
    wait_seeds(2);
    i_stat_req <= 1'b1;
    repeat (2) @(posedge txclk);
    compare_val("handshake_ack", 1, o_stat_ack);
    st = o_stat;
    compare_val("handshake_ack", {1'b1, 16'h1, 16'h0}, st);
    repeat (lane_pkg::FRAME_LEN + 8) begin
      @(posedge txclk);
      compare_val("handshake_hold", 1, o_stat_ack);
      compare_val("handshake_hold", {1'b1, 16'h1, 16'h0}, o_stat);
    end
    i_stat_req <= 1'b0;
    repeat (2) @(posedge txclk);
    compare_val("handshake_drop", 0, o_stat_ack);
    read_stat("handshake_again", st2);
    compare_val("handshake_again", {1'b1, 16'h2, 16'h0}, st2);
    end_test("handshake");

    hold_comma = 1'b1;
    apply_reset();
    repeat (2 * lane_pkg::FRAME_LEN) begin
      @(posedge txclk);
      compare_val("no_comma_edge", 0, o_aligned.valid);
    end
    read_stat("no_comma_edge", st);
    compare_val("no_comma_edge", 0, st);
    end_test("no_comma_edge");

    asrt_fails = lane_top_i.seq_check_i.lane_chk_i.fail_cnt;
    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests, fails, mism, asrt_fails);
    if (fails == 0 && asrt_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
lane_pkg.sv
frame_gen.sv
comma_decode.sv
word_align.sv
seq_check.sv
lane_top.sv
lane_chk.sv
tb_lane.sv
